// ==== common/exec_pkg.sv ====
// Execute stage package.
// Micro-instruction field positions, flag bit positions, register
// numbers, reset values and the ALU unit and function encodings
// used across the execute stage.

`default_nettype none

package exec_pkg;

  // ====================================================================
  // Micro-instruction word
  // ====================================================================
  localparam int IR_SIZE = 34;

  localparam int IR_S_LO      = 0;   // Segment select.
  localparam int IR_S_HI      = 1;
  localparam int IR_A_LO      = 2;
  localparam int IR_A_HI      = 5;
  localparam int IR_B_LO      = 6;   // Also the jump condition code.
  localparam int IR_B_HI      = 9;
  localparam int IR_C_LO      = 10;
  localparam int IR_C_HI      = 13;
  localparam int IR_D_LO      = 14;  // Destination register.
  localparam int IR_D_HI      = 17;
  localparam int IR_WRFL_LO   = 18;
  localparam int IR_WRFL_HI   = 18;
  localparam int IR_WE_LO     = 19;
  localparam int IR_WE_HI     = 19;
  localparam int IR_WR_LO     = 20;
  localparam int IR_WR_HI     = 20;
  localparam int IR_WR_CND_LO = 21;
  localparam int IR_WR_CND_HI = 21;
  localparam int IR_HIGH_LO   = 22;
  localparam int IR_HIGH_HI   = 22;
  localparam int IR_T_LO      = 23;  // Unit select.
  localparam int IR_T_HI      = 25;
  localparam int IR_FUNC_LO   = 26;
  localparam int IR_FUNC_HI   = 28;
  localparam int IR_MEMALU_LO = 30;  // Bit 29 is spare.
  localparam int IR_MEMALU_HI = 30;
  localparam int IR_M_IO_LO   = 32;  // Bit 31 is spare.
  localparam int IR_M_IO_HI   = 32;
  localparam int IR_B_IMM_LO  = 33;
  localparam int IR_B_IMM_HI  = 33;

  // ====================================================================
  // Flags and registers
  // ====================================================================
  localparam int FLAG_W = 9;

  localparam int FL_OF = 8;
  localparam int FL_DF = 7;
  localparam int FL_IF = 6;
  localparam int FL_TF = 5;
  localparam int FL_SF = 4;
  localparam int FL_ZF = 3;
  localparam int FL_AF = 2;
  localparam int FL_PF = 1;
  localparam int FL_CF = 0;

  localparam int NUM_REGS = 13;  // AX..DI, ES..DS, IP.
  localparam int REG_CX   = 1;
  localparam int REG_DX   = 2;
  localparam int REG_ES   = 8;   // First segment register.
  localparam int REG_CS   = 9;
  localparam int REG_IP   = 12;

  localparam logic [15:0] CS_RESET = 16'hF000;
  localparam logic [15:0] IP_RESET = 16'hFFF0;

  // ALU encodings.
  typedef enum logic [2:0] {
    U_ADD   = 3'd0,
    U_LOGIC = 3'd1,
    U_SHIFT = 3'd2,
    U_MUL   = 3'd3,
    U_ADDR  = 3'd4
  } alu_unit_t;

  typedef enum logic [2:0] {
    F_ADD = 3'd0,
    F_ADC = 3'd1,
    F_SUB = 3'd2,
    F_SBB = 3'd3,
    F_INC = 3'd4,
    F_DEC = 3'd5
  } add_func_t;

  typedef enum logic [2:0] {
    F_AND  = 3'd0,
    F_OR   = 3'd1,
    F_XOR  = 3'd2,
    F_NOT  = 3'd3,
    F_PASS = 3'd4
  } logic_func_t;

  typedef enum logic [2:0] {
    F_SHL = 3'd0,
    F_SHR = 3'd1,
    F_SAR = 3'd2,
    F_ROL = 3'd3,
    F_ROR = 3'd4
  } shift_func_t;

endpackage

`default_nettype wire

// ==== exec/alu.sv ====
// Execute stage ALU.
// Add, logic, shift, multiply and address units work in parallel on
// the same operands; the unit field picks one result and its flags.
// The address unit forms a 20-bit segment:offset physical address.

`default_nettype none

module alu (
  input  wire logic [15:0]                 a,
  input  wire logic [15:0]                 b,
  input  wire logic [15:0]                 c,
  input  wire logic [15:0]                 s,
  input  wire logic [15:0]                 off,
  input  wire exec_pkg::alu_unit_t         unit,
  input  wire logic [2:0]                  func,
  input  wire logic [exec_pkg::FLAG_W-1:0] iflags,
  output logic      [31:0]                 result,
  output logic      [exec_pkg::FLAG_W-1:0] oflags
);

  import exec_pkg::*;

  add_func_t   add_f;
  logic_func_t log_f;
  shift_func_t sh_f;

  assign add_f = add_func_t'(func);
  assign log_f = logic_func_t'(func);
  assign sh_f  = shift_func_t'(func);

  // Common SF, ZF, PF update on a 16-bit result.
  function automatic logic [FLAG_W-1:0] set_flags(
    input logic [FLAG_W-1:0] base,
    input logic [15:0]       res,
    input logic              of_v,
    input logic              af_v,
    input logic              cf_v
  );
    logic [FLAG_W-1:0] f;
    f        = base;
    f[FL_OF] = of_v;
    f[FL_SF] = res[15];
    f[FL_ZF] = (res == 16'h0000);
    f[FL_AF] = af_v;
    f[FL_PF] = ~^res[7:0];  // Even parity.
    f[FL_CF] = cf_v;
    return f;
  endfunction

  // ====================================================================
  // Add unit
  // ====================================================================
  logic              add_sub;
  logic [15:0]       add_y;
  logic              add_ci;
  logic [16:0]       add_sum;
  logic              add_of;
  logic              add_cf;
  logic [FLAG_W-1:0] add_fl;

  always_comb begin
    add_sub = (add_f == F_SUB) || (add_f == F_SBB) || (add_f == F_DEC);
    add_y   = (add_f == F_INC || add_f == F_DEC) ? 16'h0001 : b;
    add_ci  = (add_f == F_ADC || add_f == F_SBB) ? iflags[FL_CF] : 1'b0;
    if (add_sub) begin
      add_sum = {1'b0, a} - {1'b0, add_y} - {16'h0000, add_ci};
      add_of  = (a[15] != add_y[15]) && (add_sum[15] != a[15]);
    end else begin
      add_sum = {1'b0, a} + {1'b0, add_y} + {16'h0000, add_ci};
      add_of  = (a[15] == add_y[15]) && (add_sum[15] != a[15]);
    end
    // INC and DEC leave carry alone.
    add_cf = (add_f == F_INC || add_f == F_DEC) ? iflags[FL_CF] : add_sum[16];
    add_fl = set_flags(iflags, add_sum[15:0], add_of,
                       a[4] ^ add_y[4] ^ add_sum[4], add_cf);
  end

  // ====================================================================
  // Logic unit
  // ====================================================================
  logic [15:0]       log_res;
  logic [FLAG_W-1:0] log_fl;

  always_comb begin
    case (log_f)
      F_AND:   log_res = a & b;
      F_OR:    log_res = a | b;
      F_XOR:   log_res = a ^ b;
      F_NOT:   log_res = ~a;
      F_PASS:  log_res = c;  // Copy of register C.
      default: log_res = a;
    endcase
    log_fl = set_flags(iflags, log_res, 1'b0, iflags[FL_AF], 1'b0);
  end

  // ====================================================================
  // Shift and rotate unit
  // ====================================================================
  logic [3:0]        sh_cnt;
  logic [16:0]       sh_left;    // Carry out on top.
  logic [16:0]       sh_right;   // Carry out at bit 0.
  logic signed [16:0] sh_sar_in;
  logic signed [16:0] sh_sar;
  logic [31:0]       sh_rot_l;
  logic [31:0]       sh_rot_r;
  logic [15:0]       sh_res;
  logic              sh_cf;
  logic              sh_of;
  logic [FLAG_W-1:0] sh_fl;

  assign sh_cnt    = b[3:0];
  assign sh_sar_in = {a, 1'b0};

  always_comb begin
    sh_left  = {1'b0, a} << sh_cnt;
    sh_right = {a, 1'b0} >> sh_cnt;
    sh_sar   = sh_sar_in >>> sh_cnt;
    sh_rot_l = {a, a} << sh_cnt;
    sh_rot_r = {a, a} >> sh_cnt;
    case (sh_f)
      F_SHL: begin
        sh_res = sh_left[15:0];
        sh_cf  = sh_left[16];
        sh_of  = sh_left[15] ^ sh_left[16];
      end
      F_SHR: begin
        sh_res = sh_right[16:1];
        sh_cf  = sh_right[0];
        sh_of  = a[15];
      end
      F_SAR: begin
        sh_res = sh_sar[16:1];
        sh_cf  = sh_sar[0];
        sh_of  = 1'b0;
      end
      F_ROL: begin
        sh_res = sh_rot_l[31:16];
        sh_cf  = sh_rot_l[16];
        sh_of  = sh_rot_l[31] ^ sh_rot_l[16];
      end
      F_ROR: begin
        sh_res = sh_rot_r[15:0];
        sh_cf  = sh_rot_r[15];
        sh_of  = sh_rot_r[15] ^ sh_rot_r[14];
      end
      default: begin
        sh_res = a;
        sh_cf  = iflags[FL_CF];
        sh_of  = iflags[FL_OF];
      end
    endcase
    // Zero count keeps every flag.
    sh_fl = (sh_cnt == 4'd0) ? iflags :
            set_flags(iflags, sh_res, sh_of, iflags[FL_AF], sh_cf);
  end

  // Multiply and address units.
  logic [31:0]       mul_prod;
  logic              mul_hi;
  logic [FLAG_W-1:0] mul_fl;
  logic [19:0]       adr_res;

  assign mul_prod = a * b;
  assign mul_hi   = |mul_prod[31:16];
  assign mul_fl   = set_flags(iflags, mul_prod[15:0], mul_hi, iflags[FL_AF], mul_hi);
  assign adr_res  = {s, 4'h0} + {4'h0, a} + {4'h0, off};  // Wraps at 1 MB.

  // ====================================================================
  // Unit select
  // ====================================================================
  always_comb begin
    case (unit)
      U_ADD: begin
        result = {16'h0000, add_sum[15:0]};
        oflags = add_fl;
      end
      U_LOGIC: begin
        result = {16'h0000, log_res};
        oflags = log_fl;
      end
      U_SHIFT: begin
        result = {16'h0000, sh_res};
        oflags = sh_fl;
      end
      U_MUL: begin
        result = mul_prod;
        oflags = mul_fl;
      end
      U_ADDR: begin
        result = {12'h000, adr_res};
        oflags = iflags;
      end
      default: begin
        result = 32'h0000_0000;
        oflags = iflags;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== exec/regfile.sv ====
// Execute stage register file.
// Eight general registers, four segment registers and IP, plus the
// flags register. Three read ports, a segment read port, one write
// port and a second write path into DX for the product high half.

`default_nettype none

module regfile (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic [3:0]                  addr_a,
  input  wire logic [3:0]                  addr_b,
  input  wire logic [3:0]                  addr_c,
  input  wire logic [3:0]                  addr_d,
  input  wire logic [1:0]                  addr_s,
  input  wire logic [15:0]                 wr_data,
  input  wire logic [15:0]                 wr_high_data,
  input  wire logic                        wr,
  input  wire logic                        wr_high,
  input  wire logic                        wrfl,
  input  wire logic [exec_pkg::FLAG_W-1:0] iflags,
  output logic      [15:0]                 a,
  output logic      [15:0]                 b,
  output logic      [15:0]                 c,
  output logic      [15:0]                 s,
  output logic      [15:0]                 cs,
  output logic      [15:0]                 ip,
  output logic      [exec_pkg::FLAG_W-1:0] flags,
  output logic                             cx_zero
);

  import exec_pkg::*;

  logic [15:0] r [0:NUM_REGS-1];

  // ====================================================================
  // Write side
  // ====================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        r[i] <= 16'h0000;
      end
      r[REG_CS] <= CS_RESET;
      r[REG_IP] <= IP_RESET;
    end else begin
      if (wr && (addr_d < NUM_REGS)) begin  // 13..15 are not stored.
        r[addr_d] <= wr_data;
      end
      if (wr_high) begin
        r[REG_DX] <= wr_high_data;  // Product high half.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (wrfl) begin
      flags <= iflags;
    end
  end

  // ====================================================================
  // Read side
  // ====================================================================
  // Unused addresses read as zero.
  assign a = (addr_a < NUM_REGS) ? r[addr_a] : 16'h0000;
  assign b = (addr_b < NUM_REGS) ? r[addr_b] : 16'h0000;
  assign c = (addr_c < NUM_REGS) ? r[addr_c] : 16'h0000;

  assign s = r[REG_ES + int'(addr_s)];  // ES, CS, SS, DS.

  assign cs      = r[REG_CS];
  assign ip      = r[REG_IP];
  assign cx_zero = (r[REG_CX] == 16'h0000);

endmodule

`default_nettype wire

// ==== exec/jmp_cond.sv ====
// Jump condition evaluator.
// Checks the sixteen x86 Jcc conditions on the stored flags, or in
// CX mode the JCXZ and LOOP tests on the CX value.

`default_nettype none

module jmp_cond (
  input  wire logic [4:0]  flags5,   // OF, SF, ZF, PF, CF.
  input  wire logic [3:0]  cond,
  input  wire logic        cx_mode,
  input  wire logic [15:0] cx,
  output logic             jmp
);

  logic of;
  logic sf;
  logic zf;
  logic pf;
  logic cf;
  logic base;  // Condition before the bit 0 inversion.
  logic cx_ok;

  assign {of, sf, zf, pf, cf} = flags5;

  // Odd codes are the negation of the even code below them.
  always_comb begin
    case (cond[3:1])
      3'd0: base = of;                 // O / NO.
      3'd1: base = cf;                 // B / AE.
      3'd2: base = zf;                 // E / NE.
      3'd3: base = cf | zf;            // BE / A.
      3'd4: base = sf;                 // S / NS.
      3'd5: base = pf;                 // P / NP.
      3'd6: base = sf ^ of;            // L / GE.
      3'd7: base = (sf ^ of) | zf;     // LE / G.
      default: base = 1'b0;
    endcase
  end

  // JCXZ on bit 0 low, LOOP on bit 0 high.
  assign cx_ok = cond[0] ? (cx != 16'h0000) : (cx == 16'h0000);

  assign jmp = cx_mode ? cx_ok : (base ^ cond[0]);

endmodule

`default_nettype wire

// ==== exec/exec.sv ====
// Execute stage top level.
// Splits the micro-instruction into its fields, picks the B operand
// and the writeback word, gates register and flag writes with the
// jump condition and block, and drives the memory-side outputs.

`default_nettype none

module exec (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic [exec_pkg::IR_SIZE-1:0]  ir,
  input  wire logic [15:0]                   off,
  input  wire logic [15:0]                   imm,
  input  wire logic [15:0]                   memout,
  input  wire logic                          block,
  output logic      [15:0]                   cs,
  output logic      [15:0]                   ip,
  output logic                               of,
  output logic                               zf,
  output logic                               ifl,
  output logic                               cx_zero,
  output logic      [15:0]                   wr_data,
  output logic      [19:0]                   addr,
  output logic                               we,
  output logic                               m_io
);

  import exec_pkg::*;

  logic [1:0]        addr_s;
  logic [3:0]        addr_a;
  logic [3:0]        addr_b;
  logic [3:0]        addr_c;
  logic [3:0]        addr_d;
  logic              wrfl;
  logic              wr;
  logic              wr_cnd;
  logic              high;
  alu_unit_t         unit;
  logic [2:0]        func;
  logic              memalu;
  logic              b_imm;
  logic [15:0]       a;
  logic [15:0]       b;
  logic [15:0]       c;
  logic [15:0]       s;
  logic [15:0]       bus_b;
  logic [31:0]       alu_result;
  logic [15:0]       wb_data;
  logic [FLAG_W-1:0] flags;
  logic [FLAG_W-1:0] oflags;
  logic              jmp;
  logic              wr_reg;
  logic              wr_high;
  logic              wrfl_en;

  // ====================================================================
  // Field decode
  // ====================================================================
  assign addr_s = ir[IR_S_HI:IR_S_LO];
  assign addr_a = ir[IR_A_HI:IR_A_LO];
  assign addr_b = ir[IR_B_HI:IR_B_LO];
  assign addr_c = ir[IR_C_HI:IR_C_LO];
  assign addr_d = ir[IR_D_HI:IR_D_LO];
  assign wrfl   = ir[IR_WRFL_HI];
  assign we     = ir[IR_WE_HI];
  assign wr     = ir[IR_WR_HI];
  assign wr_cnd = ir[IR_WR_CND_HI];
  assign high   = ir[IR_HIGH_HI];
  assign unit   = alu_unit_t'(ir[IR_T_HI:IR_T_LO]);
  assign func   = ir[IR_FUNC_HI:IR_FUNC_LO];
  assign memalu = ir[IR_MEMALU_HI];
  assign m_io   = ir[IR_M_IO_HI];
  assign b_imm  = ir[IR_B_IMM_HI];

  assign bus_b   = b_imm ? imm : b;
  assign wb_data = memalu ? alu_result[15:0] : memout;

  // Write gating. A blocked cycle writes nothing.
  assign wr_reg  = (wr | (wr_cnd & jmp)) & ~block;
  assign wr_high = high & ~block;
  assign wrfl_en = wrfl & ~block;

  // Memory side.
  assign addr    = alu_result[19:0];
  assign wr_data = c;

  assign of  = flags[FL_OF];
  assign zf  = flags[FL_ZF];
  assign ifl = flags[FL_IF];

  // ====================================================================
  // Datapath blocks
  // ====================================================================
  alu u_alu (
    .a      (a),
    .b      (bus_b),
    .c      (c),
    .s      (s),
    .off    (off),
    .unit   (unit),
    .func   (func),
    .iflags (flags),
    .result (alu_result),
    .oflags (oflags)
  );

  regfile u_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_a       (addr_a),
    .addr_b       (addr_b),
    .addr_c       (addr_c),
    .addr_d       (addr_d),
    .addr_s       (addr_s),
    .wr_data      (wb_data),
    .wr_high_data (alu_result[31:16]),
    .wr           (wr_reg),
    .wr_high      (wr_high),
    .wrfl         (wrfl_en),
    .iflags       (oflags),
    .a            (a),
    .b            (b),
    .c            (c),
    .s            (s),
    .cs           (cs),
    .ip           (ip),
    .flags        (flags),
    .cx_zero      (cx_zero)
  );

  jmp_cond u_jmp_cond (
    .flags5  ({flags[FL_OF], flags[FL_SF], flags[FL_ZF], flags[FL_PF], flags[FL_CF]}),
    .cond    (addr_b),
    .cx_mode (addr_c[0]),
    .cx      (c),
    .jmp     (jmp)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Testbench clock generator.
// Free-running clock with a 40 ns period that starts low.

`default_nettype none

module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 20;  // Half of 40 ns.

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== tests/tb_exec.sv ====
// Testbench for the execute stage.
// Replays the vector file one line per cycle. Inputs change 2 ns after
// each rising edge and outputs are compared 2 ns before the next one.

`default_nettype none

module tb_exec;
  timeunit 1ns;
  timeprecision 100ps;

  import exec_pkg::*;

  localparam int MAX_VEC    = 128;
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int MARGIN     = 20;

  logic               clk;
  logic               rst_n;
  logic [IR_SIZE-1:0] ir;
  logic [15:0]        off;
  logic [15:0]        imm;
  logic [15:0]        memout;
  logic               block;
  logic [15:0]        cs;
  logic [15:0]        ip;
  logic               of;
  logic               zf;
  logic               ifl;
  logic               cx_zero;
  logic [15:0]        wr_data;
  logic [19:0]        addr;
  logic               we;
  logic               m_io;

  // Vector table, one entry per cycle.
  logic [127:0]       v_name    [0:MAX_VEC-1];
  logic [IR_SIZE-1:0] v_ir      [0:MAX_VEC-1];
  logic [15:0]        v_off     [0:MAX_VEC-1];
  logic [15:0]        v_imm     [0:MAX_VEC-1];
  logic [15:0]        v_memout  [0:MAX_VEC-1];
  logic               v_block   [0:MAX_VEC-1];
  logic               v_check   [0:MAX_VEC-1];
  logic [15:0]        v_wr_data [0:MAX_VEC-1];
  logic [19:0]        v_addr    [0:MAX_VEC-1];
  logic [4:0]         v_bits    [0:MAX_VEC-1];  // we, m_io, of, zf, cx_zero.
  logic [15:0]        v_ip      [0:MAX_VEC-1];
  logic [15:0]        v_cs      [0:MAX_VEC-1];

  int   num_vec;
  int   errors;
  logic loaded;
  logic load_ok;

  tb_clock u_clock (
    .clk (clk)
  );

  exec u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ir      (ir),
    .off     (off),
    .imm     (imm),
    .memout  (memout),
    .block   (block),
    .cs      (cs),
    .ip      (ip),
    .of      (of),
    .zf      (zf),
    .ifl     (ifl),
    .cx_zero (cx_zero),
    .wr_data (wr_data),
    .addr    (addr),
    .we      (we),
    .m_io    (m_io)
  );

  // ====================================================================
  // Vector file
  // ====================================================================
  task automatic load_vectors(output logic ok);
    int                 fd;
    int                 code;
    logic               done;
    logic [127:0]       tok;
    logic [1023:0]      rest;
    logic [IR_SIZE-1:0] t_ir;
    logic [15:0]        t_off;
    logic [15:0]        t_imm;
    logic [15:0]        t_mem;
    logic               t_blk;
    logic               t_chk;
    logic [15:0]        t_wd;
    logic [19:0]        t_addr;
    logic               t_we;
    logic               t_mio;
    logic               t_of;
    logic               t_zf;
    logic               t_cxz;
    logic [15:0]        t_ip;
    logic [15:0]        t_cs;
    ok      = 1'b1;
    done    = 1'b0;
    num_vec = 0;
    fd = $fopen("tests/exec_vectors.txt", "r");
    if (fd == 0) begin
      $display("Vector file tests/exec_vectors.txt could not be opened");
      ok = 1'b0;
    end else begin
      while (!done) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          done = 1'b1;  // End of file.
        end else if (tok == "#") begin
          code = $fgets(rest, fd);  // Column note.
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         t_ir, t_off, t_imm, t_mem, t_blk, t_chk, t_wd, t_addr,
                         t_we, t_mio, t_of, t_zf, t_cxz, t_ip, t_cs);
          if (code != 15 || num_vec >= MAX_VEC) begin
            $display("Vector %0d (%0s) is malformed or does not fit the table",
                     num_vec + 1, tok);
            ok   = 1'b0;
            done = 1'b1;
          end else begin
            v_name[num_vec]    = tok;
            v_ir[num_vec]      = t_ir;
            v_off[num_vec]     = t_off;
            v_imm[num_vec]     = t_imm;
            v_memout[num_vec]  = t_mem;
            v_block[num_vec]   = t_blk;
            v_check[num_vec]   = t_chk;
            v_wr_data[num_vec] = t_wd;
            v_addr[num_vec]    = t_addr;
            v_bits[num_vec]    = {t_we, t_mio, t_of, t_zf, t_cxz};
            v_ip[num_vec]      = t_ip;
            v_cs[num_vec]      = t_cs;
            num_vec++;
          end
        end
      end
      $fclose(fd);
      if (ok && num_vec == 0) begin
        $display("Vector file holds no vectors");
        ok = 1'b0;
      end
    end
  endtask

  task automatic compare_field(input logic [127:0] name, input string field,
                               input logic [19:0] exp, input logic [19:0] act);
    if (act !== exp) begin
      $display("ERROR %0s: %0s expected %h, got %h", name, field, exp, act);
      errors++;
    end
  endtask

  task automatic check_vector(input int i);
    compare_field(v_name[i], "wr_data", {4'h0, v_wr_data[i]}, {4'h0, wr_data});
    compare_field(v_name[i], "addr", v_addr[i], addr);
    compare_field(v_name[i], "we", {19'h0, v_bits[i][4]}, {19'h0, we});
    compare_field(v_name[i], "m_io", {19'h0, v_bits[i][3]}, {19'h0, m_io});
    compare_field(v_name[i], "of", {19'h0, v_bits[i][2]}, {19'h0, of});
    compare_field(v_name[i], "zf", {19'h0, v_bits[i][1]}, {19'h0, zf});
    compare_field(v_name[i], "cx_zero", {19'h0, v_bits[i][0]}, {19'h0, cx_zero});
    compare_field(v_name[i], "ifl", 20'h0, {19'h0, ifl});  // IF resets low, kept.
    compare_field(v_name[i], "ip", {4'h0, v_ip[i]}, {4'h0, ip});
    compare_field(v_name[i], "cs", {4'h0, v_cs[i]}, {4'h0, cs});
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    rst_n  = 1'b0;
    ir     = '0;
    off    = 16'h0000;
    imm    = 16'h0000;
    memout = 16'h0000;
    block  = 1'b0;
    errors = 0;
    loaded = 1'b0;
    load_vectors(load_ok);
    if (!load_ok) begin
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int i = 0; i < num_vec; i++) begin
        @(posedge clk);
        #2;
        ir     = v_ir[i];
        off    = v_off[i];
        imm    = v_imm[i];
        memout = v_memout[i];
        block  = v_block[i];
        #36;  // Just before the next edge.
        if (v_check[i]) begin
          check_vector(i);
        end
      end
      $display("Run done: %0d vectors, %0d errors", num_vec, errors);
      if (errors == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

  // Watchdog sized from the vector count.
  initial begin
    wait (loaded);
    #((num_vec + RST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles",
             num_vec + RST_CYCLES + MARGIN);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/exec_vectors.txt ====
# name ir off imm memout block check | wr_data addr we m_io of zf cx_zero ip cs
# all values hex, check 1 compares the outputs 2 ns before the next rising edge
rst_idle     000000000 0000 0000 0000 0 1 0000 00000 0 0 0 0 1 fff0 f000
rst_rd_ax    002000000 0000 0000 0000 0 1 0000 00000 0 0 0 0 1 fff0 f000
rst_rd_di    002001c1c 0000 0000 0000 0 1 0000 00000 0 0 0 0 1 fff0 f000
ld_ax        244900034 0000 7fff 0000 0 1 0000 07fff 0 0 0 0 1 fff0 f000
ld_bx        24490c034 0000 0001 0000 0 1 7fff 00001 0 0 0 0 1 fff0 f000
add_ax_bx    0401400c0 0000 0000 0000 0 1 7fff 08000 0 0 0 0 1 fff0 f000
rd_add       002000000 0000 0000 0000 0 1 8000 08000 0 0 1 0 1 fff0 f000
sub_ax_bx    0481400c0 0000 0000 0000 0 1 8000 07fff 0 0 1 0 1 fff0 f000
rd_sub       002000000 0000 0000 0000 0 1 7fff 07fff 0 0 1 0 1 fff0 f000
ld_bx_eq     24490c034 0000 7fff 0000 0 1 7fff 07fff 0 0 1 0 1 fff0 f000
cmp_ax_bx    0480400c0 0000 0000 0000 0 1 7fff 00000 0 0 1 0 1 fff0 f000
rd_cmp       002000000 0000 0000 0000 0 1 7fff 07fff 0 0 0 1 1 fff0 f000
ld_ax_log    244900034 0000 f0f0 0000 0 1 7fff 0f0f0 0 0 0 1 1 fff0 f000
ld_bx_log    24490c034 0000 ff00 0000 0 1 f0f0 0ff00 0 0 0 1 1 fff0 f000
set_of       200040000 0000 8000 0000 0 1 f0f0 070f0 0 0 0 1 1 fff0 f000
and_ax_bx    0409580c0 0000 0000 0000 0 1 f0f0 0f000 0 0 1 0 1 fff0 f000
rd_and       002001818 0000 0000 0000 0 1 f000 0f000 0 0 0 0 1 fff0 f000
xor_ax_bx    04895c0c0 0000 0000 0000 0 1 f0f0 00ff0 0 0 0 0 1 fff0 f000
rd_xor       002001c1c 0000 0000 0000 0 1 0ff0 00ff0 0 0 0 0 1 fff0 f000
not_ax       04c958000 0000 0000 0000 0 1 f0f0 00f0f 0 0 0 0 1 fff0 f000
rd_not       002001818 0000 0000 0000 0 1 0f0f 00f0f 0 0 0 0 1 fff0 f000
shl_ax       241118000 0000 0004 0000 0 1 f0f0 00f00 0 0 0 0 1 fff0 f000
rd_shl       002001818 0000 0000 0000 0 1 0f00 00f00 0 0 0 0 1 fff0 f000
sar_ax       24911c000 0000 0004 0000 0 1 f0f0 0ff0f 0 0 0 0 1 fff0 f000
rd_sar       002001c1c 0000 0000 0000 0 1 ff0f 0ff0f 0 0 0 0 1 fff0 f000
ror_ax       25111c000 0000 0004 0000 0 1 f0f0 00f0f 0 0 0 0 1 fff0 f000
rd_ror       002001c1c 0000 0000 0000 0 1 0f0f 00f0f 0 0 0 0 1 fff0 f000
ld_ax_mul    244900034 0000 1234 0000 0 1 f0f0 01234 0 0 0 0 1 fff0 f000
ld_bx_mul    24490c034 0000 0100 0000 0 1 1234 00100 0 0 0 0 1 fff0 f000
mul_ax_bx    041d400c0 0000 0000 0000 0 1 1234 23400 0 0 0 0 1 fff0 f000
rd_mul_lo    002000000 0000 0000 0000 0 1 3400 03400 0 0 1 0 1 fff0 f000
rd_mul_hi    002000808 0000 0000 0000 0 1 0012 00012 0 0 1 0 1 fff0 f000
ld_ds        24492c034 0000 1000 0000 0 1 3400 01000 0 0 1 0 1 fff0 f000
ld_si        244918034 0000 0234 0000 0 1 3400 00234 0 0 1 0 1 fff0 f000
mem_wr       10208001b 0010 0000 0000 0 1 3400 10244 1 1 1 0 1 fff0 f000
mem_rd       10211c01b 0010 0000 beef 0 1 3400 10244 0 1 1 0 1 fff0 f000
rd_mem       002001c1c 0000 0000 0000 0 1 beef 0beef 0 0 1 0 1 fff0 f000
ld_ss        244928034 0000 ffff 0000 0 1 3400 0ffff 0 0 1 0 1 fff0 f000
addr_wrap    00200001e 1000 0000 0000 0 1 3400 0cedf 0 0 1 0 1 fff0 f000
cmp_eq       208040000 0000 3400 0000 0 1 3400 00000 0 0 1 0 1 fff0 f000
cnd_e_hit    244a18134 0000 5a5a 0000 0 1 3400 05a5a 0 0 0 1 1 fff0 f000
rd_cnd_hit   002001818 0000 0000 0000 0 1 5a5a 05a5a 0 0 0 1 1 fff0 f000
cmp_ne       208040000 0000 0001 0000 0 1 3400 033ff 0 0 0 1 1 fff0 f000
cnd_e_miss   244a18134 0000 a5a5 0000 0 1 3400 0a5a5 0 0 0 0 1 fff0 f000
rd_cnd_miss  002001818 0000 0000 0000 0 1 5a5a 05a5a 0 0 0 0 1 fff0 f000
loop_miss    244a1c474 0000 1111 0000 0 1 0000 01111 0 0 0 0 1 fff0 f000
rd_loop_miss 002001c1c 0000 0000 0000 0 1 beef 0beef 0 0 0 0 1 fff0 f000
ld_cx        244904034 0000 0003 0000 0 1 3400 00003 0 0 0 0 1 fff0 f000
loop_hit     244a1c474 0000 1111 0000 0 1 0003 01111 0 0 0 0 0 fff0 f000
rd_loop_hit  002001c1c 0000 0000 0000 0 1 1111 01111 0 0 0 0 0 fff0 f000
blk_wr       24491c034 0000 2222 0000 1 1 3400 02222 0 0 0 0 0 fff0 f000
blk_fl       208040000 0000 3400 0000 1 1 3400 00000 0 0 0 0 0 fff0 f000
rd_blk       002001c1c 0000 0000 0000 0 1 1111 01111 0 0 0 0 0 fff0 f000
idle_end     000000000 0000 0000 0000 0 1 3400 06800 0 0 0 0 0 fff0 f000

// ==== files.f ====
common/exec_pkg.sv
exec/alu.sv
exec/regfile.sv
exec/jmp_cond.sv
exec/exec.sv
tests/tb_clock.sv
tests/tb_exec.sv
